// File: hdl/mac_pkg.sv
// Widths, sizes, vector types and state encodings shared by the controller and its testbench.
package mac_pkg;

    // Client side.
    localparam int NUM_PORTS = 2;
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // Storage sizes.
    localparam int IFR_DEPTH = 8;
    localparam int QUEUE_DEPTH = 4;
    localparam int CACHE_LINES = 8;
    localparam int STORE_WORDS = 64;

    // Cycles the backing store spends on each request.
    localparam int STORE_LATENCY = 4;

    // Derived index widths.
    localparam int IFR_IDX_W = $clog2(IFR_DEPTH);
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int CIDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = ADDR_W - CIDX_W;
    localparam int STORE_IDX_W = $clog2(STORE_WORDS);
    localparam int LAT_W = $clog2(STORE_LATENCY);

    // Word address; low bits index the cache and the store.
    typedef logic [ADDR_W-1:0] addr_t;

    // One data word.
    typedef logic [DATA_W-1:0] data_t;

    // Originating client port.
    typedef logic [$clog2(NUM_PORTS)-1:0] port_id_t;

    // Cache stage FSM.
    typedef enum logic [1:0] {
        CS_LOOKUP,
        CS_EVICT,
        CS_FORWARD,
        CS_RETURN
    } cache_state_t;

    // Backing store FSM.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_RESPOND
    } store_state_t;

endpackage

// File: hdl/mac_scheduler.sv
// Input side of the controller; picks one client request per cycle and tracks in-flight addresses.
`timescale 1ns/100ps

module mac_scheduler import mac_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_PORTS-1:0] req_valid,
    input  logic [NUM_PORTS-1:0] req_write,
    input  addr_t                req_addr [NUM_PORTS],
    input  data_t                req_data [NUM_PORTS],
    output logic [NUM_PORTS-1:0] req_ready,
    output logic                 in_valid,
    output logic                 in_write,
    output addr_t                in_addr,
    output data_t                in_data,
    output port_id_t             in_port,
    input  logic                 in_ready,
    input  logic                 retire,
    input  addr_t                retire_addr
);

    // In-flight address table.
    logic [IFR_DEPTH-1:0] ifr_valid;
    addr_t                ifr_addr [IFR_DEPTH];
    logic                 ifr_full;
    logic [IFR_IDX_W-1:0] free_slot;

    // Per-port address clash against the table.
    logic [NUM_PORTS-1:0] clash;
    logic                 found;

    // Table occupancy and lowest free slot.
    always_comb begin
        ifr_full = &ifr_valid;
        free_slot = '0;
        // Scan downward so the lowest free index wins.
        for (int j = IFR_DEPTH - 1; j >= 0; j--) begin
            if (!ifr_valid[j]) begin
                free_slot = IFR_IDX_W'(j);
            end
        end
    end

    // A port clashes when its address is already in flight.
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            clash[p] = 1'b0;
            for (int j = 0; j < IFR_DEPTH; j++) begin
                if (ifr_valid[j] && ifr_addr[j] == req_addr[p]) begin
                    clash[p] = 1'b1;
                end
            end
        end
    end

    // Fixed priority, lowest port first.
    always_comb begin
        found = 1'b0;
        req_ready = '0;
        in_write = 1'b0;
        in_addr = '0;
        in_data = '0;
        in_port = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!found && req_valid[p] && !clash[p] && !ifr_full) begin
                found = 1'b1;
                in_write = req_write[p];
                in_addr = req_addr[p];
                in_data = req_data[p];
                in_port = port_id_t'(p);
                // Acceptance passes straight through from the cache stage.
                req_ready[p] = in_ready;
            end
        end
        in_valid = found;
    end

    // Slot valid bits; retire and allocate never touch the same slot.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifr_valid <= '0;
        end else begin
            for (int j = 0; j < IFR_DEPTH; j++) begin
                if (retire && ifr_valid[j] && ifr_addr[j] == retire_addr) begin
                    ifr_valid[j] <= 1'b0;
                end
            end
            if (in_valid && in_ready) begin
                ifr_valid[free_slot] <= 1'b1;
            end
        end
    end

    // Log the accepted address.
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            ifr_addr[free_slot] <= in_addr;
        end
    end

endmodule

// File: hdl/mac_cache_stage.sv
// Processing part of the controller; queued requests run through a direct-mapped write-back cache.
`timescale 1ns/100ps

module mac_cache_stage import mac_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  logic     in_write,
    input  addr_t    in_addr,
    input  data_t    in_data,
    input  port_id_t in_port,
    output logic     in_ready,
    output logic     fwd_valid,
    output logic     fwd_write,
    output addr_t    fwd_addr,
    output data_t    fwd_data,
    output port_id_t fwd_port,
    input  logic     fwd_ready,
    output logic     cmp_valid,
    output logic     cmp_write,
    output addr_t    cmp_addr,
    output data_t    cmp_data,
    output port_id_t cmp_port,
    input  logic     cmp_ready
);

    // Request queue.
    logic              q_write [QUEUE_DEPTH];
    addr_t             q_addr [QUEUE_DEPTH];
    data_t             q_data [QUEUE_DEPTH];
    port_id_t          q_port [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QPTR_W:0]   q_count;
    logic              push;
    logic              pop;

    // Cache lines.
    logic [CACHE_LINES-1:0] line_valid;
    logic [CACHE_LINES-1:0] line_dirty;
    logic [TAG_W-1:0]       line_tag [CACHE_LINES];
    data_t                  line_data [CACHE_LINES];

    // Head of the queue and its line.
    logic              head_write;
    addr_t             head_addr;
    data_t             head_data;
    port_id_t          head_port;
    logic [CIDX_W-1:0] idx;
    logic [TAG_W-1:0]  tag;
    logic              hit;
    logic              install;

    cache_state_t state;
    cache_state_t state_next;

    assign in_ready = (q_count != (QPTR_W + 1)'(QUEUE_DEPTH));
    assign push = in_valid && in_ready;

    assign head_write = q_write[rd_ptr];
    assign head_addr = q_addr[rd_ptr];
    assign head_data = q_data[rd_ptr];
    assign head_port = q_port[rd_ptr];
    assign idx = head_addr[CIDX_W-1:0];
    assign tag = head_addr[ADDR_W-1:CIDX_W];
    assign hit = line_valid[idx] && line_tag[idx] == tag;

    // Forward carries either the evicted word or the missed read.
    assign fwd_write = (state == CS_EVICT);
    assign fwd_addr = (state == CS_EVICT) ? {line_tag[idx], idx} : head_addr;
    assign fwd_data = line_data[idx];
    assign fwd_port = head_port;

    // Line already holds the written word or the hit data.
    assign cmp_write = head_write;
    assign cmp_addr = head_addr;
    assign cmp_data = line_data[idx];
    assign cmp_port = head_port;

    // Next state and the handshake levels.
    always_comb begin
        state_next = state;
        pop = 1'b0;
        install = 1'b0;
        fwd_valid = 1'b0;
        cmp_valid = 1'b0;
        case (state)
            CS_LOOKUP: begin
                if (q_count != '0) begin
                    if (head_write) begin
                        // Dirty line of another tag goes out first.
                        if (line_valid[idx] && line_dirty[idx] && line_tag[idx] != tag) begin
                            state_next = CS_EVICT;
                        end else begin
                            install = 1'b1;
                            state_next = CS_RETURN;
                        end
                    end else if (hit) begin
                        state_next = CS_RETURN;
                    end else begin
                        state_next = CS_FORWARD;
                    end
                end
            end
            CS_EVICT: begin
                fwd_valid = 1'b1;
                if (fwd_ready) begin
                    install = 1'b1;
                    state_next = CS_RETURN;
                end
            end
            CS_FORWARD: begin
                // The store answers this one itself.
                fwd_valid = 1'b1;
                if (fwd_ready) begin
                    pop = 1'b1;
                    state_next = CS_LOOKUP;
                end
            end
            CS_RETURN: begin
                cmp_valid = 1'b1;
                if (cmp_ready) begin
                    pop = 1'b1;
                    state_next = CS_LOOKUP;
                end
            end
            default: state_next = CS_LOOKUP;
        endcase
    end

    // Control state.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CS_LOOKUP;
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_count <= '0;
            line_valid <= '0;
            line_dirty <= '0;
        end else begin
            state <= state_next;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                q_count <= q_count + 1'b1;
            end else if (!push && pop) begin
                q_count <= q_count - 1'b1;
            end
            if (install) begin
                line_valid[idx] <= 1'b1;
                line_dirty[idx] <= 1'b1;
            end
        end
    end

    // Queue entries and line contents.
    always_ff @(posedge clk) begin
        if (push) begin
            q_write[wr_ptr] <= in_write;
            q_addr[wr_ptr] <= in_addr;
            q_data[wr_ptr] <= in_data;
            q_port[wr_ptr] <= in_port;
        end
        if (install) begin
            line_tag[idx] <= tag;
            line_data[idx] <= head_data;
        end
    end

endmodule

// File: hdl/mac_backing_store.sv
// Word store behind the cache; serves forwarded reads and writes one at a time after a fixed delay.
`timescale 1ns/100ps

module mac_backing_store import mac_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fwd_valid,
    input  logic     fwd_write,
    input  addr_t    fwd_addr,
    input  data_t    fwd_data,
    input  port_id_t fwd_port,
    output logic     fwd_ready,
    output logic     cmp_valid,
    output logic     cmp_write,
    output addr_t    cmp_addr,
    output data_t    cmp_data,
    output port_id_t cmp_port,
    input  logic     cmp_ready
);

    data_t mem [STORE_WORDS];

    store_state_t     state;
    logic [LAT_W-1:0] lat_cnt;

    // Request being served.
    logic                   op_write;
    addr_t                  op_addr;
    data_t                  op_data;
    port_id_t               op_port;
    logic [STORE_IDX_W-1:0] op_idx;

    assign op_idx = op_addr[STORE_IDX_W-1:0];
    assign fwd_ready = (state == ST_IDLE);

    // Read result, held until taken.
    assign cmp_valid = (state == ST_RESPOND);
    assign cmp_write = op_write;
    assign cmp_addr = op_addr;
    assign cmp_data = mem[op_idx];
    assign cmp_port = op_port;

    // FSM, latency count and store contents.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            lat_cnt <= '0;
            for (int i = 0; i < STORE_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (state)
                ST_IDLE: begin
                    if (fwd_valid) begin
                        state <= ST_BUSY;
                        lat_cnt <= '0;
                    end
                end
                ST_BUSY: begin
                    // Last busy cycle.
                    if (lat_cnt == LAT_W'(STORE_LATENCY - 1)) begin
                        if (op_write) begin
                            mem[op_idx] <= op_data;
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_RESPOND;
                        end
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                ST_RESPOND: begin
                    if (cmp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Capture the accepted request.
    always_ff @(posedge clk) begin
        if (fwd_valid && fwd_ready) begin
            op_write <= fwd_write;
            op_addr <= fwd_addr;
            op_data <= fwd_data;
            op_port <= fwd_port;
        end
    end

endmodule

// File: hdl/mac_return_arbiter.sv
// Output side of the controller; merges cache and store completions and routes them to their ports.
`timescale 1ns/100ps

module mac_return_arbiter import mac_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 c_valid,
    input  logic                 c_write,
    input  addr_t                c_addr,
    input  data_t                c_data,
    input  port_id_t             c_port,
    output logic                 c_ready,
    input  logic                 s_valid,
    input  logic                 s_write,
    input  addr_t                s_addr,
    input  data_t                s_data,
    input  port_id_t             s_port,
    output logic                 s_ready,
    output logic [NUM_PORTS-1:0] rsp_valid,
    output logic                 rsp_write,
    output addr_t                rsp_addr,
    output data_t                rsp_data,
    input  logic [NUM_PORTS-1:0] rsp_ready,
    output logic                 retire,
    output addr_t                retire_addr
);

    logic taken;

    // Cache source first, store second.
    always_comb begin
        rsp_valid = '0;
        c_ready = 1'b0;
        s_ready = 1'b0;
        rsp_write = c_valid ? c_write : s_write;
        rsp_addr = c_valid ? c_addr : s_addr;
        rsp_data = c_valid ? c_data : s_data;
        if (c_valid) begin
            rsp_valid[c_port] = 1'b1;
            c_ready = rsp_ready[c_port];
        end else if (s_valid) begin
            rsp_valid[s_port] = 1'b1;
            s_ready = rsp_ready[s_port];
        end
    end

    assign taken = (c_valid && c_ready) || (s_valid && s_ready);

    // One-cycle retire pulse after a port takes its response.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire <= 1'b0;
        end else begin
            retire <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (taken) begin
            retire_addr <= rsp_addr;
        end
    end

endmodule

// File: hdl/memory_access_controller.sv
// Top level of the memory access controller; joins scheduler, cache stage, store and return arbiter.
`timescale 1ns/100ps

module memory_access_controller import mac_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_PORTS-1:0] req_valid,
    input  logic [NUM_PORTS-1:0] req_write,
    input  addr_t                req_addr [NUM_PORTS],
    input  data_t                req_data [NUM_PORTS],
    output logic [NUM_PORTS-1:0] req_ready,
    output logic [NUM_PORTS-1:0] rsp_valid,
    output logic                 rsp_write,
    output addr_t                rsp_addr,
    output data_t                rsp_data,
    input  logic [NUM_PORTS-1:0] rsp_ready
);

    // Scheduler to cache stage.
    logic     in_valid;
    logic     in_write;
    addr_t    in_addr;
    data_t    in_data;
    port_id_t in_port;
    logic     in_ready;

    // Cache stage to store.
    logic     fwd_valid;
    logic     fwd_write;
    addr_t    fwd_addr;
    data_t    fwd_data;
    port_id_t fwd_port;
    logic     fwd_ready;

    // Completions from the cache stage.
    logic     c_valid;
    logic     c_write;
    addr_t    c_addr;
    data_t    c_data;
    port_id_t c_port;
    logic     c_ready;

    // Completions from the store.
    logic     s_valid;
    logic     s_write;
    addr_t    s_addr;
    data_t    s_data;
    port_id_t s_port;
    logic     s_ready;

    // Retirement back to the scheduler.
    logic  retire;
    addr_t retire_addr;

    mac_scheduler scheduler_inst (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
        .req_data(req_data), .req_ready(req_ready),
        .in_valid(in_valid), .in_write(in_write), .in_addr(in_addr),
        .in_data(in_data), .in_port(in_port), .in_ready(in_ready),
        .retire(retire), .retire_addr(retire_addr)
    );

    mac_cache_stage cache_stage_inst (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_write(in_write), .in_addr(in_addr),
        .in_data(in_data), .in_port(in_port), .in_ready(in_ready),
        .fwd_valid(fwd_valid), .fwd_write(fwd_write), .fwd_addr(fwd_addr),
        .fwd_data(fwd_data), .fwd_port(fwd_port), .fwd_ready(fwd_ready),
        .cmp_valid(c_valid), .cmp_write(c_write), .cmp_addr(c_addr),
        .cmp_data(c_data), .cmp_port(c_port), .cmp_ready(c_ready)
    );

    mac_backing_store backing_store_inst (
        .clk(clk), .rst_n(rst_n),
        .fwd_valid(fwd_valid), .fwd_write(fwd_write), .fwd_addr(fwd_addr),
        .fwd_data(fwd_data), .fwd_port(fwd_port), .fwd_ready(fwd_ready),
        .cmp_valid(s_valid), .cmp_write(s_write), .cmp_addr(s_addr),
        .cmp_data(s_data), .cmp_port(s_port), .cmp_ready(s_ready)
    );

    mac_return_arbiter return_arbiter_inst (
        .clk(clk), .rst_n(rst_n),
        .c_valid(c_valid), .c_write(c_write), .c_addr(c_addr),
        .c_data(c_data), .c_port(c_port), .c_ready(c_ready),
        .s_valid(s_valid), .s_write(s_write), .s_addr(s_addr),
        .s_data(s_data), .s_port(s_port), .s_ready(s_ready),
        .rsp_valid(rsp_valid), .rsp_write(rsp_write), .rsp_addr(rsp_addr),
        .rsp_data(rsp_data), .rsp_ready(rsp_ready),
        .retire(retire), .retire_addr(retire_addr)
    );

endmodule

// File: verif/mac_clock_gen.sv
// Testbench clock and reset source; a 4 ns clock with reset held low for the first 8 cycles.
`timescale 1ns/100ps

module mac_clock_gen (
    output logic clk,
    output logic rst_n
);

    // Free-running clock, 2 ns per half period.
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Release reset on a falling edge, clear of the sampling edge.
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: verif/mac_tb.sv
// Testbench top for the memory access controller; runs the stimulus table and reports the result.
`timescale 1ns/100ps

module mac_tb import mac_pkg::*; ();

    localparam int NUM_ROWS = 12;
    localparam int ROW_TIMEOUT = 200;
    localparam int RESET_TIMEOUT = 50;

    // One port slot of a table row.
    typedef struct packed {
        logic  en;
        logic  wr;
        addr_t addr;
        data_t data;
        data_t exp;
    } slot_t;

    localparam slot_t IDLE_SLOT = '0;

    logic                 clk;
    logic                 rst_n;
    logic [NUM_PORTS-1:0] req_valid;
    logic [NUM_PORTS-1:0] req_write;
    addr_t                req_addr [NUM_PORTS];
    data_t                req_data [NUM_PORTS];
    logic [NUM_PORTS-1:0] req_ready;
    logic [NUM_PORTS-1:0] rsp_valid;
    logic                 rsp_write;
    addr_t                rsp_addr;
    data_t                rsp_data;
    logic [NUM_PORTS-1:0] rsp_ready;

    // Expected memory contents, filled on each accepted write.
    data_t       ref_mem [addr_t];
    logic [31:0] lcg_state = 32'd47598;
    bit          timed_out = 1'b0;

    string row_name [NUM_ROWS] = '{
        "write then read, write", "write then read, hit", "unwritten read",
        "eviction, write A", "eviction, write B", "eviction, read A",
        "routing, port 1 alone", "clash blocking", "back-pressure, cache hit",
        "back-pressure, store read", "back-pressure, write", "both ports"
    };

    // Each slot holds enable, write, address, data and expected read value.
    slot_t row_slot [NUM_ROWS][NUM_PORTS] = '{
        '{'{1'b1, 1'b1, 16'h0005, 32'hA5A5_0001, 32'h0}, IDLE_SLOT},
        '{'{1'b1, 1'b0, 16'h0005, 32'h0, 32'hA5A5_0001}, IDLE_SLOT},
        '{'{1'b1, 1'b0, 16'h002A, 32'h0, 32'h0}, IDLE_SLOT},
        '{'{1'b1, 1'b1, 16'h0011, 32'h1111_0011, 32'h0}, IDLE_SLOT},
        '{'{1'b1, 1'b1, 16'h0019, 32'h1919_0019, 32'h0}, IDLE_SLOT},
        '{'{1'b1, 1'b0, 16'h0011, 32'h0, 32'h1111_0011}, IDLE_SLOT},
        '{IDLE_SLOT, '{1'b1, 1'b0, 16'h0019, 32'h0, 32'h1919_0019}},
        '{'{1'b1, 1'b1, 16'h0022, 32'hC0DE_0022, 32'h0},
          '{1'b1, 1'b0, 16'h0022, 32'h0, 32'hC0DE_0022}},
        '{'{1'b1, 1'b0, 16'h0005, 32'h0, 32'hA5A5_0001}, IDLE_SLOT},
        '{IDLE_SLOT, '{1'b1, 1'b0, 16'h0011, 32'h0, 32'h1111_0011}},
        '{'{1'b1, 1'b1, 16'h0030, 32'h3030_0030, 32'h0}, IDLE_SLOT},
        '{'{1'b1, 1'b0, 16'h002A, 32'h0, 32'h0},
          '{1'b1, 1'b1, 16'h002B, 32'hBEEF_002B, 32'h0}}
    };

    // Rows that hold rsp_ready low for a while.
    logic row_bp [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 0};

    mac_clock_gen clock_gen_inst (
        .clk(clk),
        .rst_n(rst_n)
    );

    memory_access_controller memory_access_controller_inst (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
        .req_data(req_data), .req_ready(req_ready),
        .rsp_valid(rsp_valid), .rsp_write(rsp_write), .rsp_addr(rsp_addr),
        .rsp_data(rsp_data), .rsp_ready(rsp_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Never written words read as zero.
    function automatic data_t ref_read(input addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return '0;
    endfunction

    // Drives one table row and follows it until every response is taken.
    task automatic run_row(input int r, output bit ok);
        int                   cyc;
        int                   hold_left;
        bit                   holding;
        addr_t                held_addr;
        data_t                held_data;
        int                   acc_cyc [NUM_PORTS];
        int                   take_cyc [NUM_PORTS];
        data_t                exp_val [NUM_PORTS];
        logic [NUM_PORTS-1:0] wait_acc;
        logic [NUM_PORTS-1:0] wait_rsp;
        logic [NUM_PORTS-1:0] drive_valid;
        ok = 1'b1;
        cyc = 0;
        holding = 1'b0;
        hold_left = 0;
        held_addr = '0;
        held_data = '0;
        wait_rsp = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            wait_acc[p] = row_slot[r][p].en;
            acc_cyc[p] = 0;
            take_cyc[p] = 0;
            exp_val[p] = '0;
        end
        drive_valid = wait_acc;
        @(posedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            req_write[p] <= row_slot[r][p].wr;
            req_addr[p] <= row_slot[r][p].addr;
            req_data[p] <= row_slot[r][p].data;
        end
        req_valid <= drive_valid;
        rsp_ready <= row_bp[r] ? '0 : '1;
        while ((wait_acc != '0 || wait_rsp != '0) && cyc < ROW_TIMEOUT) begin
            @(posedge clk);
            cyc++;
            for (int p = 0; p < NUM_PORTS; p++) begin
                // Responses are checked first against the flags of the previous cycle.
                if (wait_rsp[p]) begin
                    if (holding && !rsp_valid[p]) begin
                        $display("ERROR: row %0d port %0d response dropped while held", r, p);
                        ok = 1'b0;
                    end
                    if (holding && rsp_addr !== held_addr) begin
                        $display("MISMATCH row %0d port %0d held rsp_addr: got %h expected %h",
                                 r, p, rsp_addr, held_addr);
                        ok = 1'b0;
                    end
                    if (holding && rsp_data !== held_data) begin
                        $display("MISMATCH row %0d port %0d held rsp_data: got %h expected %h",
                                 r, p, rsp_data, held_data);
                        ok = 1'b0;
                    end
                    if (rsp_valid[p] && rsp_ready[p]) begin
                        if (rsp_write !== row_slot[r][p].wr) begin
                            $display("MISMATCH row %0d port %0d rsp_write: got %h expected %h",
                                     r, p, rsp_write, row_slot[r][p].wr);
                            ok = 1'b0;
                        end
                        if (rsp_addr !== row_slot[r][p].addr) begin
                            $display("MISMATCH row %0d port %0d rsp_addr: got %h expected %h",
                                     r, p, rsp_addr, row_slot[r][p].addr);
                            ok = 1'b0;
                        end
                        if (!row_slot[r][p].wr && rsp_data !== exp_val[p]) begin
                            $display("MISMATCH row %0d port %0d rsp_data: got %h expected %h",
                                     r, p, rsp_data, exp_val[p]);
                            ok = 1'b0;
                        end
                        wait_rsp[p] = 1'b0;
                        take_cyc[p] = cyc;
                        holding = 1'b0;
                    end else if (rsp_valid[p] && !holding) begin
                        // Hold the response back for a pseudo-random time.
                        lcg_state = lcg_next(lcg_state);
                        hold_left = 3 + int'(lcg_state[18:16]);
                        holding = 1'b1;
                        held_addr = rsp_addr;
                        held_data = rsp_data;
                    end
                end else if (rsp_valid[p]) begin
                    $display("ERROR: row %0d response on port %0d with no request pending", r, p);
                    ok = 1'b0;
                end
                // Request side.
                if (wait_acc[p] && req_ready[p]) begin
                    wait_acc[p] = 1'b0;
                    wait_rsp[p] = 1'b1;
                    acc_cyc[p] = cyc;
                    drive_valid[p] = 1'b0;
                    if (row_slot[r][p].wr) begin
                        ref_mem[row_slot[r][p].addr] = row_slot[r][p].data;
                    end else begin
                        exp_val[p] = ref_read(row_slot[r][p].addr);
                        if (exp_val[p] !== row_slot[r][p].exp) begin
                            $display("ERROR: row %0d port %0d table expects %h but model has %h",
                                     r, p, row_slot[r][p].exp, exp_val[p]);
                            ok = 1'b0;
                        end
                    end
                end
            end
            req_valid <= drive_valid;
            if (holding && hold_left > 0) begin
                hold_left--;
                if (hold_left == 0) begin
                    rsp_ready <= '1;
                end
            end
        end
        if (wait_acc != '0 || wait_rsp != '0) begin
            $display("ERROR: row %0d timed out waiting for the controller", r);
            ok = 1'b0;
            timed_out = 1'b1;
        end else if (row_slot[r][0].en && row_slot[r][1].en
                     && row_slot[r][0].addr == row_slot[r][1].addr) begin
            // Second port must wait until the first port's response is taken.
            if (!(acc_cyc[0] < acc_cyc[1] && acc_cyc[1] > take_cyc[0])) begin
                $display("ERROR: row %0d port 1 accepted before port 0 was answered", r);
                ok = 1'b0;
            end
        end
        req_valid <= '0;
    endtask

    initial begin
        int passed;
        int failed;
        int cyc;
        bit ok;
        passed = 0;
        failed = 0;
        cyc = 0;
        req_valid <= '0;
        req_write <= '0;
        rsp_ready <= '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            req_addr[p] <= '0;
            req_data[p] <= '0;
        end
        while (rst_n !== 1'b1 && cyc < RESET_TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        if (rst_n !== 1'b1) begin
            $display("ERROR: reset was never released");
            failed++;
        end else begin
            @(posedge clk);
            // Nothing may be ready or valid straight out of reset.
            if (req_ready !== '0 || rsp_valid !== '0) begin
                $display("ERROR: controller outputs not idle after reset");
                failed++;
            end
            for (int r = 0; r < NUM_ROWS; r++) begin
                run_row(r, ok);
                if (ok) begin
                    passed++;
                    $display("row %0d %s: pass", r, row_name[r]);
                end else begin
                    failed++;
                    $display("row %0d %s: FAIL", r, row_name[r]);
                end
                if (timed_out) begin
                    break;
                end
            end
        end
        $display("Tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: all.f
hdl/mac_pkg.sv
hdl/mac_scheduler.sv
hdl/mac_cache_stage.sv
hdl/mac_backing_store.sv
hdl/mac_return_arbiter.sv
hdl/memory_access_controller.sv
verif/mac_clock_gen.sv
verif/mac_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module mac_tb -f all.f \
    && ./obj_dir/Vmac_tb | tee /dev/stderr | grep -qx "Everything OK" \
    || { echo "Simulation did not pass"; exit 1; }
echo "Simulation passed"
